// ==== dv/dp_slice_cases.txt ====
# one cycle per line: H addr data | U word expected | S addr expected (or none) | I
# all numbers hex, A-memory and M-memory addresses as in the microinstruction
I
I
I
# host loads into A
H 01 12345678
H 02 0F0F00FF
H 03 00000001
H 04 FFFFFFFF
H 05 A5A5C3C3
H 06 80000000
# pass A into M words 1 to 6
U 00404020 12345678
U 00808020 0F0F00FF
U 00C0C020 00000001
U 01010020 FFFFFFFF
U 01414020 A5A5C3C3
U 01818020 80000000
I
I
S 01 12345678
S 06 80000000
S 03 00000001
# alu ops on M[1] and A[2] into A[20], then wrap cases
U 48008200 12345678
U 48008220 0F0F00FF
U 48008240 21435777
U 48008250 21435778
U 48008270 03255579
U 48008260 03255578
U 48008280 02040078
U 480082A0 1F3F56FF
U 480082C0 1D3B5687
U 480082E0 EDCBA987
U 48008320 00000000
U 480083E0 00000000
U 4800C850 00000001
U 48010670 00000002
# byte form into A[21]
U C841420F A5A55678
U C8414287 A5A5C312
U C8414243 A5A5C3C1
U C84143F0 A5A5C3C2
U C841430B A5A5C234
U C841054F FFFFF0F0
# M[7] rewritten, readers one, two and three cycles later
U 01C04020 12345678
I
I
U 01C18020 80000000
U 48804E00 12345678
U 48804E00 12345678
U 48804E00 80000000
# spy lands on an M writeback and is dropped
U 02014020 A5A5C3C3
I
S 08 none
S 08 A5A5C3C3
S 07 80000000
I
I
I

// ==== dp_slice.f ====
rtl/dp_slice_pkg.sv
rtl/part_32x32dpram.sv
rtl/part_amem_dpram.sv
rtl/alu_shifter.sv
rtl/dest_pipe.sv
rtl/dp_slice_top.sv
dv/clk_gen.sv
dv/dp_slice_tb.sv

// ==== dv/dp_slice_tb.sv ====
`timescale 1ns/100ps

module dp_slice_tb;

   localparam int MAX_CASES    = 256;
   localparam int DRAIN_CYCLES = 8;
   localparam logic [4:0] UNWRITTEN_M_ADDR = 5'd31;   // never a destination

   logic        clk_a;
   logic        reset;
   logic        uinst_valid;
   logic [31:0] uinst;
   logic [31:0] result;
   logic        result_valid;
   logic        host_wr;
   logic [7:0]  host_addr;
   logic [31:0] host_data;
   logic        spy_rd;
   logic [4:0]  spy_addr;
   logic [31:0] spy_data;
   logic        spy_valid;

   logic [7:0]  case_kind [0:MAX_CASES-1];   // one entry per case line
   logic [31:0] case_a    [0:MAX_CASES-1];
   logic [31:0] case_b    [0:MAX_CASES-1];
   logic        case_none [0:MAX_CASES-1];   // spy expected to be dropped
   int          case_line [0:MAX_CASES-1];
   int          num_cases;
   int          idx;

   logic [31:0] exp_result_q [$];
   int          exp_result_line [$];
   logic [31:0] exp_spy_q [$];
   int          exp_spy_line [$];

   int result_errors;
   int spy_errors;
   int other_errors;
   int cycle_count;
   int cycle_limit;
   int drain;

   clk_gen i_clk (
      .clk_a (clk_a),
      .reset (reset)
   );

   dp_slice_top i_dut (
      .clk_a        (clk_a),
      .reset        (reset),
      .uinst_valid  (uinst_valid),
      .uinst        (uinst),
      .result       (result),
      .result_valid (result_valid),
      .host_wr      (host_wr),
      .host_addr    (host_addr),
      .host_data    (host_data),
      .spy_rd       (spy_rd),
      .spy_addr     (spy_addr),
      .spy_data     (spy_data),
      .spy_valid    (spy_valid)
   );

   task load_cases;
      int          fd;
      int          n;
      int          line_no;
      string       line;
      logic [7:0]  kind_ch;
      logic [31:0] val_a;
      logic [31:0] val_b;
      begin
         num_cases = 0;
         line_no   = 0;
         fd = $fopen("dv/dp_slice_cases.txt", "r");
         if (fd == 0)
         begin
            $display("case file dv/dp_slice_cases.txt could not be opened");
            other_errors++;
         end
         else
         begin
            while ($fgets(line, fd) != 0)
            begin
               line_no++;
               if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != 8'h0a)
               begin
                  val_a = '0;
                  val_b = '0;
                  n = $sscanf(line, "%c %h %h", kind_ch, val_a, val_b);
                  if (num_cases >= MAX_CASES)
                  begin
                     $display("case file has more than %0d cases", MAX_CASES);
                     other_errors++;
                  end
                  else if (((kind_ch == "H" || kind_ch == "U") && n == 3) ||
                           (kind_ch == "S" && n >= 2) || kind_ch == "I")
                  begin
                     case_kind[num_cases] = kind_ch;
                     case_a[num_cases]    = val_a;
                     case_b[num_cases]    = val_b;
                     case_none[num_cases] = (kind_ch == "S" && n == 2);   // data "none"
                     case_line[num_cases] = line_no;
                     num_cases++;
                  end
                  else
                  begin
                     $display("case file line %0d is not understood", line_no);
                     other_errors++;
                  end
               end
            end
            $fclose(fd);
         end
         if (num_cases == 0)
         begin
            $display("case file holds no cases");
            other_errors++;
         end
      end
   endtask

   task apply_case(input int n);
      begin
         uinst_valid = 1'b0;
         uinst       = '0;
         host_wr     = 1'b0;
         spy_rd      = 1'b0;
         case (case_kind[n])
            "U":
            begin
               uinst_valid = 1'b1;
               uinst       = case_a[n];
               exp_result_q.push_back(case_b[n]);
               exp_result_line.push_back(case_line[n]);
            end
            "H":
            begin
               host_wr   = 1'b1;
               host_addr = case_a[n][7:0];
               host_data = case_b[n];
            end
            "S":
            begin
               spy_rd   = 1'b1;
               spy_addr = case_a[n][4:0];
               if (!case_none[n])
               begin
                  exp_spy_q.push_back(case_b[n]);
                  exp_spy_line.push_back(case_line[n]);
               end
            end
         endcase
      end
   endtask

   task check_reset_state;
      begin
         if (result_valid !== 1'b0)
         begin
            $display("ERROR result_valid after reset: expected 0, got %h", result_valid);
            result_errors++;
         end
         if (result !== 32'h0)
         begin
            $display("ERROR result after reset: expected 00000000, got %08h", result);
            result_errors++;
         end
         if (spy_valid !== 1'b0)
         begin
            $display("ERROR spy_valid after reset: expected 0, got %h", spy_valid);
            spy_errors++;
         end
         if (spy_data !== 32'h0)
         begin
            $display("ERROR spy_data after reset: expected 00000000, got %08h", spy_data);
            spy_errors++;
         end
      end
   endtask

   // an M word that nothing has written yet reads as zero
   task spy_unwritten_word;
      begin
         @(posedge clk_a);
         #0.5;
         spy_rd   = 1'b1;
         spy_addr = UNWRITTEN_M_ADDR;
         exp_spy_q.push_back(32'h0);
         exp_spy_line.push_back(0);   // not from a case line
      end
   endtask

   task check_result;
      logic [31:0] expected;
      int          line_no;
      begin
         if (exp_result_q.size() == 0)
         begin
            $display("result_valid went high with no instruction outstanding");
            other_errors++;
         end
         else
         begin
            expected = exp_result_q.pop_front();
            line_no  = exp_result_line.pop_front();
            if (result !== expected)
            begin
               $display("ERROR result: expected %08h, got %08h (case line %0d)",
                        expected, result, line_no);
               result_errors++;
            end
         end
      end
   endtask

   task check_spy;
      logic [31:0] expected;
      int          line_no;
      begin
         if (exp_spy_q.size() == 0)
         begin
            $display("spy_valid went high with no spy read outstanding");
            other_errors++;
         end
         else
         begin
            expected = exp_spy_q.pop_front();
            line_no  = exp_spy_line.pop_front();
            if (spy_data !== expected)
            begin
               $display("ERROR spy_data: expected %08h, got %08h (case line %0d)",
                        expected, spy_data, line_no);
               spy_errors++;
            end
         end
      end
   endtask

   task report_counts;
      begin
         $display("errors: result %0d, spy %0d, other %0d, total %0d", result_errors,
                  spy_errors, other_errors, result_errors + spy_errors + other_errors);
      end
   endtask

   // outputs sampled at the edge, before the DUT registers update
   always @(posedge clk_a)
   begin
      if (reset === 1'b0)
      begin
         if (result_valid === 1'b1)
         begin
            check_result();
         end
         if (spy_valid === 1'b1)
         begin
            check_spy();
         end
      end
   end

   always @(posedge clk_a)
   begin
      cycle_count++;
      if (cycle_count > cycle_limit)
      begin
         $display("timeout: the run did not end within %0d cycles", cycle_limit);
         report_counts();
         $display("TEST FAIL");
         $finish;
      end
   end

   initial
   begin
      uinst_valid   = 1'b0;
      uinst         = '0;
      host_wr       = 1'b0;
      host_addr     = '0;
      host_data     = '0;
      spy_rd        = 1'b0;
      spy_addr      = '0;
      result_errors = 0;
      spy_errors    = 0;
      other_errors  = 0;
      cycle_count   = 0;
      drain         = 0;
      load_cases();
      cycle_limit = 4 * num_cases + 50;
      @(negedge reset);
      check_reset_state();
      spy_unwritten_word();
      for (idx = 0; idx < num_cases; idx++)
      begin
         @(posedge clk_a);
         #0.5;
         apply_case(idx);
      end
      @(posedge clk_a);
      #0.5;
      uinst_valid = 1'b0;   // back to idle
      host_wr     = 1'b0;
      spy_rd      = 1'b0;
      while ((exp_result_q.size() != 0 || exp_spy_q.size() != 0) && drain < DRAIN_CYCLES)
      begin
         @(posedge clk_a);
         #1;
         drain++;
      end
      repeat (3) @(posedge clk_a);   // room for a stray valid
      #1;
      while (exp_result_q.size() != 0)
      begin
         $display("result_valid never came for case line %0d", exp_result_line.pop_front());
         void'(exp_result_q.pop_front());
         other_errors++;
      end
      while (exp_spy_q.size() != 0)
      begin
         $display("spy_valid never came for case line %0d", exp_spy_line.pop_front());
         void'(exp_spy_q.pop_front());
         other_errors++;
      end
      report_counts();
      if (result_errors + spy_errors + other_errors == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen
(
   output logic clk_a,
   output logic reset
);

   localparam real HALF_PERIOD  = 2.0;   // 4 ns clock
   localparam int  RESET_CYCLES = 3;

   initial
   begin
      clk_a = 1'b0;
      forever
      begin
         #HALF_PERIOD clk_a = ~clk_a;
      end
   end

   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_a);
      #0.5;
      reset = 1'b0;   // released just after an edge like other inputs
   end

endmodule

// ==== rtl/dp_slice_top.sv ====
`timescale 1ns/100ps

module dp_slice_top
   import dp_slice_pkg::*;
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                uinst_valid,
   input  uinst_t              uinst,
   output logic [DATA_W-1:0]   result,
   output logic                result_valid,
   input  logic                host_wr,
   input  logic [A_ADDR_W-1:0] host_addr,
   input  logic [DATA_W-1:0]   host_data,
   input  logic                spy_rd,
   input  logic [M_ADDR_W-1:0] spy_addr,
   output logic [DATA_W-1:0]   spy_data,
   output logic                spy_valid
);

   logic [DATA_W-1:0]   m_q;
   logic [DATA_W-1:0]   a_q;
   logic [M_ADDR_W-1:0] m_addr_b;
   logic [DATA_W-1:0]   m_data_b;
   logic                m_wren_b;
   logic                m_rden_b;
   logic [A_ADDR_W-1:0] a_addr_b;
   logic [DATA_W-1:0]   a_data_b;
   logic                a_wren_b;

   // port a is the operand read port only
   part_32x32dpram i_mmem (
      .reset     (reset),
      .clk_a     (clk_a),
      .address_a (uinst.alu.m_src),
      .data_a    ('0),
      .wren_a    (1'b0),
      .rden_a    (uinst_valid),
      .address_b (m_addr_b),
      .data_b    (m_data_b),
      .wren_b    (m_wren_b),
      .rden_b    (m_rden_b),
      .q_a       (m_q),
      .q_b       (spy_data)   // spy read data
   );

   part_amem_dpram i_amem (
      .reset     (reset),
      .clk_a     (clk_a),
      .address_a (uinst.alu.a_src),
      .data_a    ('0),
      .wren_a    (1'b0),
      .rden_a    (uinst_valid),
      .address_b (a_addr_b),
      .data_b    (a_data_b),
      .wren_b    (a_wren_b),
      .rden_b    (1'b0),      // no readback on A port b
      .q_a       (a_q),
      .q_b       ()
   );

   alu_shifter i_alu (
      .clk_a        (clk_a),
      .reset        (reset),
      .uinst_valid  (uinst_valid),
      .uinst        (uinst),
      .m_q          (m_q),
      .a_q          (a_q),
      .result       (result),
      .result_valid (result_valid)
   );

   dest_pipe i_dest (
      .clk_a        (clk_a),
      .reset        (reset),
      .uinst_valid  (uinst_valid),
      .uinst        (uinst),
      .result       (result),
      .result_valid (result_valid),
      .host_wr      (host_wr),
      .host_addr    (host_addr),
      .host_data    (host_data),
      .spy_rd       (spy_rd),
      .spy_addr     (spy_addr),
      .m_addr_b     (m_addr_b),
      .m_data_b     (m_data_b),
      .m_wren_b     (m_wren_b),
      .m_rden_b     (m_rden_b),
      .a_addr_b     (a_addr_b),
      .a_data_b     (a_data_b),
      .a_wren_b     (a_wren_b),
      .spy_valid    (spy_valid)
   );

endmodule

// ==== rtl/dest_pipe.sv ====
`timescale 1ns/100ps

module dest_pipe
   import dp_slice_pkg::*;
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                uinst_valid,
   input  uinst_t              uinst,
   input  logic [DATA_W-1:0]   result,
   input  logic                result_valid,
   input  logic                host_wr,
   input  logic [A_ADDR_W-1:0] host_addr,
   input  logic [DATA_W-1:0]   host_data,
   input  logic                spy_rd,
   input  logic [M_ADDR_W-1:0] spy_addr,
   output logic [M_ADDR_W-1:0] m_addr_b,
   output logic [DATA_W-1:0]   m_data_b,
   output logic                m_wren_b,
   output logic                m_rden_b,
   output logic [A_ADDR_W-1:0] a_addr_b,
   output logic [DATA_W-1:0]   a_data_b,
   output logic                a_wren_b,
   output logic                spy_valid
);

   logic                d1_is_a;
   logic [A_ADDR_W-1:0] d1_addr;
   logic                d2_is_a;   // lines up with result
   logic [A_ADDR_W-1:0] d2_addr;
   logic                m_wb;
   logic                a_wb;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         d1_is_a <= 1'b0;
         d1_addr <= '0;
         d2_is_a <= 1'b0;
         d2_addr <= '0;
      end
      else
      begin
         if (uinst_valid)
         begin
            d1_is_a <= uinst.alu.dest_is_a;
            d1_addr <= uinst.alu.dest_addr;
         end
         d2_is_a <= d1_is_a;
         d2_addr <= d1_addr;
      end
   end

   // writeback due at the coming edge
   assign m_wb = result_valid & ~d2_is_a;
   assign a_wb = result_valid & d2_is_a;

   // M port b, writeback or spy read
   assign m_addr_b = m_wb ? d2_addr[M_ADDR_W-1:0] : spy_addr;
   assign m_data_b = result;
   assign m_wren_b = m_wb;
   assign m_rden_b = spy_rd & ~m_wb;   // spy dropped under writeback

   // A port b, writeback or host load
   assign a_addr_b = a_wb ? d2_addr : host_addr;
   assign a_data_b = a_wb ? result : host_data;
   assign a_wren_b = a_wb | host_wr;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         spy_valid <= 1'b0;
      end
      else
      begin
         spy_valid <= m_rden_b;   // q_b loads at the same edge
      end
   end

endmodule

// ==== rtl/alu_shifter.sv ====
`timescale 1ns/100ps

module alu_shifter
   import dp_slice_pkg::*;
(
   input  logic              clk_a,
   input  logic              reset,
   input  logic              uinst_valid,
   input  uinst_t            uinst,
   input  logic [DATA_W-1:0] m_q,
   input  logic [DATA_W-1:0] a_q,
   output logic [DATA_W-1:0] result,
   output logic              result_valid
);

   // operation fields, captured alongside the memory read
   logic               s_valid;
   logic               s_kind;
   logic [OP_W-1:0]    s_alu_op;
   logic               s_carry_in;
   logic [ROT_W-1:0]   s_rotate;
   logic [WIDTH_W-1:0] s_width;

   logic [DATA_W-1:0]   alu_out;
   logic [DATA_W-1:0]   byte_out;
   logic [2*DATA_W-1:0] rot_wide;
   logic [DATA_W-1:0]   rotated;
   logic [DATA_W-1:0]   field_mask;
   logic [DATA_W-1:0]   next_result;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s_valid    <= 1'b0;
         s_kind     <= 1'b0;
         s_alu_op   <= '0;
         s_carry_in <= 1'b0;
         s_rotate   <= '0;
         s_width    <= '0;
      end
      else
      begin
         s_valid    <= uinst_valid;
         s_kind     <= uinst.alu.kind;
         s_alu_op   <= uinst.alu.alu_op;   // same bits as rotate/width in byte form
         s_carry_in <= uinst.alu.carry_in;
         s_rotate   <= uinst.byt.rotate;
         s_width    <= uinst.byt.width;
      end
   end

   always_comb
   begin
      case (s_alu_op)
         OP_PASS_M: alu_out = m_q;
         OP_PASS_A: alu_out = a_q;
         OP_ADD:    alu_out = m_q + a_q + {{(DATA_W-1){1'b0}}, s_carry_in};
         OP_SUB:    alu_out = m_q + ~a_q + {{(DATA_W-1){1'b0}}, s_carry_in};
         OP_AND:    alu_out = m_q & a_q;
         OP_OR:     alu_out = m_q | a_q;
         OP_XOR:    alu_out = m_q ^ a_q;
         OP_NOT_M:  alu_out = ~m_q;
         default:   alu_out = '0;   // unused codes
      endcase
   end

   always_comb
   begin
      rot_wide   = {m_q, m_q} << s_rotate;   // rotate left
      rotated    = rot_wide[2*DATA_W-1:DATA_W];
      field_mask = (32'd2 << s_width) - 32'd1;   // bits 0..width
      byte_out   = (rotated & field_mask) | (a_q & ~field_mask);
   end

   assign next_result = s_kind ? byte_out : alu_out;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         result       <= '0;
         result_valid <= 1'b0;
      end
      else
      begin
         result       <= next_result;
         result_valid <= s_valid;   // one cycle per instruction
      end
   end

endmodule

// ==== rtl/part_amem_dpram.sv ====
`timescale 1ns/100ps

module part_amem_dpram
   import dp_slice_pkg::*;
(
   input  logic                reset,
   input  logic                clk_a,
   input  logic [A_ADDR_W-1:0] address_a,
   input  logic [DATA_W-1:0]   data_a,
   input  logic                wren_a,
   input  logic                rden_a,
   input  logic [A_ADDR_W-1:0] address_b,
   input  logic [DATA_W-1:0]   data_b,
   input  logic                wren_b,
   input  logic                rden_b,
   output logic [DATA_W-1:0]   q_a,
   output logic [DATA_W-1:0]   q_b
);

   logic [DATA_W-1:0] ram [0:A_DEPTH-1];

   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         ram[address_a] <= data_a;
      end
      else if (wren_b)
      begin
         ram[address_b] <= data_b;   // writeback or host load
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (rden_a)
      begin
         q_a <= ram[address_a];
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (rden_b)
      begin
         q_b <= ram[address_b];
      end
   end

endmodule

// ==== rtl/part_32x32dpram.sv ====
`timescale 1ns/100ps

module part_32x32dpram
   import dp_slice_pkg::*;
(
   input  logic                reset,
   input  logic                clk_a,
   input  logic [M_ADDR_W-1:0] address_a,
   input  logic [DATA_W-1:0]   data_a,
   input  logic                wren_a,
   input  logic                rden_a,
   input  logic [M_ADDR_W-1:0] address_b,
   input  logic [DATA_W-1:0]   data_b,
   input  logic                wren_b,
   input  logic                rden_b,
   output logic [DATA_W-1:0]   q_a,
   output logic [DATA_W-1:0]   q_b
);

   logic [DATA_W-1:0] ram [0:M_DEPTH-1];

   initial
   begin
      for (int i = 0; i < M_DEPTH; i++)
      begin
         ram[i] = '0;   // unwritten words read as zero
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         ram[address_a] <= data_a;   // port a wins a collision
      end
      else if (wren_b)
      begin
         ram[address_b] <= data_b;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (rden_a)
      begin
         q_a <= ram[address_a];   // old data during a write
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (rden_b)
      begin
         q_b <= ram[address_b];
      end
   end

endmodule

// ==== rtl/dp_slice_pkg.sv ====
package dp_slice_pkg;

   localparam int DATA_W   = 32;

   // M memory, the small scratchpad
   localparam int M_ADDR_W = 5;
   localparam int M_DEPTH  = 32;

   // A memory
   localparam int A_ADDR_W = 8;
   localparam int A_DEPTH  = 256;

   localparam int ROT_W    = 5;
   localparam int WIDTH_W  = 4;
   localparam int OP_W     = 4;

   // alu operation codes, 8 to 15 give zero
   localparam logic [OP_W-1:0] OP_PASS_M = 4'd0;
   localparam logic [OP_W-1:0] OP_PASS_A = 4'd1;
   localparam logic [OP_W-1:0] OP_ADD    = 4'd2;   // m + a + carry_in
   localparam logic [OP_W-1:0] OP_SUB    = 4'd3;   // m + ~a + carry_in
   localparam logic [OP_W-1:0] OP_AND    = 4'd4;
   localparam logic [OP_W-1:0] OP_OR     = 4'd5;
   localparam logic [OP_W-1:0] OP_XOR    = 4'd6;
   localparam logic [OP_W-1:0] OP_NOT_M  = 4'd7;

   typedef struct packed {
      logic                kind;       // 0 for alu form
      logic                dest_is_a;
      logic [A_ADDR_W-1:0] dest_addr;  // low bits only for M
      logic [A_ADDR_W-1:0] a_src;
      logic [M_ADDR_W-1:0] m_src;
      logic [OP_W-1:0]     alu_op;
      logic                carry_in;
      logic [3:0]          unused;
   } alu_uinst_t;

   // byte form, field of width+1 bits after rotating M left
   typedef struct packed {
      logic                kind;       // 1 for byte form
      logic                dest_is_a;
      logic [A_ADDR_W-1:0] dest_addr;
      logic [A_ADDR_W-1:0] a_src;
      logic [M_ADDR_W-1:0] m_src;
      logic [ROT_W-1:0]    rotate;
      logic [WIDTH_W-1:0]  width;
   } byte_uinst_t;

   typedef union packed {
      alu_uinst_t  alu;
      byte_uinst_t byt;
   } uinst_t;

endpackage
